/* logic/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  typedef logic [31:0] wordT;
  typedef logic [3:0]  regNumT;   // 16-entry bank, low four bits of each field

  typedef enum logic [6:0] {
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opBranch = 7'b1100011,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd      = 4'h0,
    aluSub      = 4'h1,
    aluOr       = 4'h2,
    aluXor      = 4'h3,
    aluAnd      = 4'h4,
    aluLessU    = 4'h5,
    aluLess     = 4'h6,
    aluShrU     = 4'h7,
    aluShrS     = 4'h8,
    aluShlU     = 4'h9,
    aluShlS     = 4'hA,
    aluGeU      = 4'hB,
    aluGe       = 4'hC,
    aluEqual    = 4'hD,
    aluNotEqual = 4'hE
  } aluOpT;

  // What goes to rd
  typedef enum logic [1:0] {
    resNone,
    resAlu,
    resImm,
    resPcPlus4
  } resultSelT;

  typedef enum logic [1:0] {
    pcSeq,
    pcBranch,
    pcJal,
    pcJalr
  } nextPcSelT;

  typedef struct packed {
    wordT      pc;
    regNumT    rs1;
    regNumT    rs2;
    regNumT    rd;
    wordT      imm;
    aluOpT     aluOp;
    logic      useImm;    // ALU Y is the immediate
    logic      usePc;     // ALU X is the PC
    resultSelT resultSel;
    nextPcSelT nextPcSel;
  } decodedT;

  localparam wordT resetPc    = 32'h0000_0000;
  localparam wordT instrBytes = 32'd4;

endpackage

`default_nettype wire

/* logic/decodeIf.sv */
`default_nettype none

// Decoded instruction from decoder to execute unit
interface decodeIf import cpuPkg::*; ();

  logic    valid;
  logic    ready;
  decodedT instr;   // Held stable while valid waits for ready

  modport decoder (
    output valid,
    output instr,
    input  ready
  );

  modport execute (
    input  valid,
    input  instr,
    output ready
  );

endinterface

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

module instrDecoder import cpuPkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        fetchReq,
  input  wire wordT  fetchPc,
  input  wire        fetchReady,
  input  wire wordT  fetchData,
  output logic       fetchValid,
  output wordT       fetchAddr,
  decodeIf.decoder   dec
);

  logic [2:0] funct3;
  logic       altBit;      // funct7 bit 5, also imm bit 10 for srai
  wordT       immI;
  wordT       immU;
  wordT       immB;
  wordT       immJ;
  decodedT    decoded;

  assign funct3 = fetchData[14:12];
  assign altBit = fetchData[30];

  // Shift immediates stay unextended
  assign immI = (fetchData[6:0] == opImm && (funct3 == 3'd1 || funct3 == 3'd5))
                ? {20'b0, fetchData[31:20]}
                : {{20{fetchData[31]}}, fetchData[31:20]};
  assign immU = {fetchData[31:12], 12'b0};
  assign immB = {{19{fetchData[31]}}, fetchData[31], fetchData[7], fetchData[30:25],
                 fetchData[11:8], 1'b0};
  assign immJ = {{11{fetchData[31]}}, fetchData[31], fetchData[19:12], fetchData[20],
                 fetchData[30:21], 1'b0};

  // Shared funct3 map of the two ALU groups
  function automatic aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    aluOpFor = alt ? aluSub : aluAdd;
      3'd1:    aluOpFor = aluShlU;
      3'd2:    aluOpFor = aluLess;
      3'd3:    aluOpFor = aluLessU;
      3'd4:    aluOpFor = aluXor;
      3'd5:    aluOpFor = alt ? aluShrS : aluShrU;
      3'd6:    aluOpFor = aluOr;
      default: aluOpFor = aluAnd;
    endcase
  endfunction

  always_comb
  begin
    decoded           = '0;
    decoded.pc        = fetchAddr;
    decoded.rs1       = fetchData[18:15];
    decoded.rs2       = fetchData[23:20];
    decoded.rd        = fetchData[10:7];
    decoded.aluOp     = aluAdd;
    decoded.resultSel = resNone;
    decoded.nextPcSel = pcSeq;
    case (opcodeT'(fetchData[6:0]))
      opImm:
      begin
        decoded.imm       = immI;
        decoded.aluOp     = aluOpFor(funct3, (funct3 == 3'd5) && altBit);  // No subi
        decoded.useImm    = 1'b1;
        decoded.resultSel = resAlu;
      end
      opReg:
      begin
        decoded.aluOp     = aluOpFor(funct3, altBit);
        decoded.resultSel = resAlu;
      end
      opBranch:
      begin
        decoded.imm = immB;
        case (funct3)
          3'd0:    decoded.aluOp = aluEqual;
          3'd1:    decoded.aluOp = aluNotEqual;
          3'd4:    decoded.aluOp = aluLess;
          3'd5:    decoded.aluOp = aluGe;
          3'd6:    decoded.aluOp = aluLessU;
          default: decoded.aluOp = aluGeU;
        endcase
        if (funct3 != 3'd2 && funct3 != 3'd3)
          decoded.nextPcSel = pcBranch;   // Reserved conditions fall through
      end
      opLui:
      begin
        decoded.imm       = immU;
        decoded.resultSel = resImm;
      end
      opAuipc:
      begin
        decoded.imm       = immU;
        decoded.useImm    = 1'b1;
        decoded.usePc     = 1'b1;
        decoded.resultSel = resAlu;
      end
      opJal:
      begin
        decoded.imm       = immJ;
        decoded.resultSel = resPcPlus4;
        decoded.nextPcSel = pcJal;
      end
      opJalr:
      begin
        decoded.imm       = immI;
        decoded.useImm    = 1'b1;
        decoded.resultSel = resPcPlus4;
        decoded.nextPcSel = pcJalr;
      end
      default:
      begin
        decoded.resultSel = resNone;    // Unknown opcode is a no-op
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fetchValid <= 1'b0;
      dec.valid  <= 1'b0;
    end
    else
    begin
      if (fetchReq)
      begin
        fetchValid <= 1'b1;
        fetchAddr  <= fetchPc;
      end
      else if (fetchValid && fetchReady)
      begin
        fetchValid <= 1'b0;
        dec.instr  <= decoded;
        dec.valid  <= 1'b1;
      end
      if (dec.valid && dec.ready)
        dec.valid <= 1'b0;       // Handed to execute
    end
  end

  // Bus request holds under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    fetchValid && !fetchReady |=> fetchValid && $stable(fetchAddr));

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`default_nettype none

module aluUnit import cpuPkg::*; (
  input  wire aluOpT op,
  input  wire wordT  x,
  input  wire wordT  y,
  output wordT       result
);

  logic [4:0] shamt;
  logic       lessS;
  logic       lessU;
  logic       equal;

  assign shamt = y[4:0];
  assign lessS = $signed(x) < $signed(y);
  assign lessU = x < y;
  assign equal = x == y;

  always_comb
  begin
    case (op)
      aluAdd:
        result = x + y;
      aluSub:
        result = x - y;
      aluOr:
        result = x | y;
      aluXor:
        result = x ^ y;
      aluAnd:
        result = x & y;
      aluLessU:
        result = {31'b0, lessU};
      aluLess:
        result = {31'b0, lessS};
      aluShrU:
        result = x >> shamt;
      aluShrS:
        result = wordT'($signed(x) >>> shamt);
      aluShlU,
      aluShlS:
        result = x << shamt;      // Left shift is the same either way
      aluGeU:
        result = {31'b0, !lessU};
      aluGe:
        result = {31'b0, !lessS};
      aluEqual:
        result = {31'b0, equal};
      aluNotEqual:
        result = {31'b0, !equal};
      default:
        result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`default_nettype none

module executeUnit import cpuPkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire wordT  regOutA,
  input  wire wordT  regOutB,
  input  wire wordT  aluO,
  output regNumT     regNumA,
  output regNumT     regNumB,
  output aluOpT      aluOp,
  output wordT       aluX,
  output wordT       aluY,
  output logic       regWriteValid,
  output regNumT     regWriteNum,
  output wordT       regWriteData,
  output logic       fetchReq,
  output wordT       fetchPc,
  decodeIf.execute   dec
);

  typedef enum logic {
    sIdle,
    sExec
  } stateT;

  stateT     state;
  wordT      curPc;
  wordT      curImm;
  regNumT    curRd;
  resultSelT curResultSel;
  nextPcSelT curNextPcSel;
  wordT      pcPlus4;
  wordT      target;
  wordT      nextPc;
  wordT      writeData;

  // Operands read straight from the offered instruction
  assign regNumA   = dec.instr.rs1;
  assign regNumB   = dec.instr.rs2;
  assign dec.ready = (state == sIdle);

  assign pcPlus4 = curPc + instrBytes;
  assign target  = curPc + curImm;

  always_comb
  begin
    case (curNextPcSel)
      pcBranch: nextPc = aluO[0] ? target : pcPlus4;   // Compare result in bit 0
      pcJal:    nextPc = target;
      pcJalr:   nextPc = {aluO[31:1], 1'b0};
      default:  nextPc = pcPlus4;
    endcase
  end

  always_comb
  begin
    case (curResultSel)
      resImm:     writeData = curImm;
      resPcPlus4: writeData = pcPlus4;
      default:    writeData = aluO;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= sIdle;
      regWriteValid <= 1'b0;
      fetchReq      <= 1'b1;       // First fetch request leaves reset with us
      fetchPc       <= resetPc;
    end
    else
    begin
      regWriteValid <= 1'b0;
      fetchReq      <= 1'b0;
      case (state)
        sIdle:
        begin
          if (dec.valid)
          begin
            curPc        <= dec.instr.pc;
            curImm       <= dec.instr.imm;
            curRd        <= dec.instr.rd;
            curResultSel <= dec.instr.resultSel;
            curNextPcSel <= dec.instr.nextPcSel;
            aluOp        <= dec.instr.aluOp;
            aluX         <= dec.instr.usePc ? dec.instr.pc : regOutA;
            aluY         <= dec.instr.useImm ? dec.instr.imm : regOutB;
            state        <= sExec;
          end
        end
        sExec:
        begin
          // Commit and ask for the next instruction together
          regWriteValid <= (curResultSel != resNone);
          regWriteNum   <= curRd;
          regWriteData  <= writeData;
          fetchReq      <= 1'b1;
          fetchPc       <= nextPc;
          state         <= sIdle;
        end
        default:
          state <= sIdle;
      endcase
    end
  end

  // Nothing of the previous instruction overlaps a new transfer
  assert property (@(posedge clk) disable iff (reset)
    (dec.valid && dec.ready) |-> !(regWriteValid || fetchReq));

endmodule

`default_nettype wire

/* logic/registerBank.sv */
`default_nettype none

module registerBank import cpuPkg::*; (
  input  wire         clk,
  input  wire         reset,
  input  wire regNumT regNumA,
  input  wire regNumT regNumB,
  input  wire         writeValid,
  input  wire regNumT writeNum,
  input  wire wordT   writeData,
  output wordT        regOutA,
  output wordT        regOutB
);

  wordT regs [16];

  assign regOutA = regs[regNumA];
  assign regOutB = regs[regNumB];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 16; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeValid && writeNum != '0)
    begin
      regs[writeNum] <= writeData;   // x0 stays zero
    end
  end

  // x0 reads as zero on both ports
  assert property (@(posedge clk) disable iff (reset)
    regNumA == '0 |-> regOutA == '0);

  assert property (@(posedge clk) disable iff (reset)
    regNumB == '0 |-> regOutB == '0);

endmodule

`default_nettype wire

/* logic/rv32Core.sv */
`default_nettype none

module rv32Core import cpuPkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        fetchReady,
  input  wire wordT  fetchData,
  output logic       fetchValid,
  output wordT       fetchAddr,
  output logic       regWriteValid,
  output regNumT     regWriteNum,
  output wordT       regWriteData
);

  logic   fetchReq;
  wordT   fetchPc;
  regNumT regNumA;
  regNumT regNumB;
  wordT   regOutA;
  wordT   regOutB;
  aluOpT  aluOp;
  wordT   aluX;
  wordT   aluY;
  wordT   aluO;

  decodeIf decBus ();

  instrDecoder decoder (
    .clk        (clk),
    .reset      (reset),
    .fetchReq   (fetchReq),
    .fetchPc    (fetchPc),
    .fetchReady (fetchReady),
    .fetchData  (fetchData),
    .fetchValid (fetchValid),
    .fetchAddr  (fetchAddr),
    .dec        (decBus.decoder)
  );

  executeUnit execute (
    .clk           (clk),
    .reset         (reset),
    .regOutA       (regOutA),
    .regOutB       (regOutB),
    .aluO          (aluO),
    .regNumA       (regNumA),
    .regNumB       (regNumB),
    .aluOp         (aluOp),
    .aluX          (aluX),
    .aluY          (aluY),
    .regWriteValid (regWriteValid),
    .regWriteNum   (regWriteNum),
    .regWriteData  (regWriteData),
    .fetchReq      (fetchReq),
    .fetchPc       (fetchPc),
    .dec           (decBus.execute)
  );

  aluUnit alu (
    .op     (aluOp),
    .x      (aluX),
    .y      (aluY),
    .result (aluO)
  );

  // Commit port doubles as the bank write port
  registerBank regBank (
    .clk        (clk),
    .reset      (reset),
    .regNumA    (regNumA),
    .regNumB    (regNumB),
    .writeValid (regWriteValid),
    .writeNum   (regWriteNum),
    .writeData  (regWriteData),
    .regOutA    (regOutA),
    .regOutB    (regOutB)
  );

endmodule

`default_nettype wire

/* test/rvModel.svh */
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// Architectural state of the reference model
wordT mRegs [16];
wordT mPc;

function automatic wordT aluCalc(input logic [2:0] f3, input logic alt, input wordT a,
                                 input wordT y);
  case (f3)
    3'd0:    return alt ? a - y : a + y;
    3'd1:    return a << y[4:0];
    3'd2:    return {31'b0, $signed(a) < $signed(y)};
    3'd3:    return {31'b0, a < y};
    3'd4:    return a ^ y;
    3'd5:    return alt ? wordT'($signed(a) >>> y[4:0]) : a >> y[4:0];
    3'd6:    return a | y;
    default: return a & y;
  endcase
endfunction

// Runs one instruction on the model and reports the expected commit and next PC
function automatic void modelExec(input wordT ins, output logic wr, output regNumT rd,
                                  output wordT val, output wordT nextPc);
  logic [2:0] f3;
  wordT       a;
  wordT       b;
  wordT       immI;
  wordT       immU;
  logic       take;
  f3     = ins[14:12];
  rd     = ins[10:7];
  a      = mRegs[ins[18:15]];
  b      = mRegs[ins[23:20]];
  immI   = {{20{ins[31]}}, ins[31:20]};
  immU   = {ins[31:12], 12'b0};
  wr     = 1'b1;
  val    = '0;
  take   = 1'b0;
  nextPc = mPc + 32'd4;
  case (ins[6:0])
    7'b0010011:
      val = aluCalc(f3, f3 == 3'd5 && ins[30], a,
                    (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, ins[24:20]} : immI);
    7'b0110011: val = aluCalc(f3, ins[30], a, b);
    7'b0110111: val = immU;
    7'b0010111: val = mPc + immU;
    7'b1101111:
    begin
      val    = mPc + 32'd4;
      nextPc = mPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    7'b1100111:
    begin
      val    = mPc + 32'd4;
      nextPc = (a + immI) & ~32'd1;
    end
    7'b1100011:
    begin
      wr = 1'b0;
      case (f3)
        3'd0:    take = a == b;
        3'd1:    take = a != b;
        3'd4:    take = $signed(a) < $signed(b);
        3'd5:    take = $signed(a) >= $signed(b);
        3'd6:    take = a < b;
        3'd7:    take = a >= b;
        default: take = 1'b0;   // Reserved conditions
      endcase
      if (take)
        nextPc = mPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    end
    default: wr = 1'b0;
  endcase
  if (wr && rd != '0)
    mRegs[rd] = val;
  mPc = nextPc;
endfunction

function automatic wordT rnd();
  return $random(seed);
endfunction

function automatic logic [4:0] randReg();
  return {1'b0, 4'(rnd())};
endfunction

function automatic wordT randAlu();
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm;
  logic        alt;
  f3  = 3'(rnd());
  rd  = randReg();
  rs1 = randReg();
  rs2 = randReg();
  alt = 1'(rnd());
  if (1'(rnd()))
    return {((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd,
            7'b0110011};
  case (f3)
    3'd1:    imm = {7'b0, 5'(rnd())};
    3'd5:    imm = {alt ? 7'b0100000 : 7'b0, 5'(rnd())};
    default: imm = 12'(rnd());
  endcase
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

`endif

/* test/coreTb.sv */
`default_nettype none

module coreTb import cpuPkg::*; ;
  timeunit 1ns;
  timeprecision 1ps;

  logic   clk;
  logic   reset;
  logic   fetchReady;
  wordT   fetchData;
  logic   fetchValid;
  wordT   fetchAddr;
  logic   regWriteValid;
  regNumT regWriteNum;
  wordT   regWriteData;

  integer seed       = 32'h741b_e4dd;
  int     readyPct   = 70;   // Chance of fetchReady per cycle
  int     errors     = 0;
  int     testErrors = 0;
  int     testsRun   = 0;
  int     testsBad   = 0;

  `include "rvModel.svh"

  rv32Core dut_i (
    .clk           (clk),
    .reset         (reset),
    .fetchReady    (fetchReady),
    .fetchData     (fetchData),
    .fetchValid    (fetchValid),
    .fetchAddr     (fetchAddr),
    .regWriteValid (regWriteValid),
    .regWriteNum   (regWriteNum),
    .regWriteData  (regWriteData)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compareVal(input string name, input wordT got, input wordT exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      errors++;
      testErrors++;
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (testErrors > 0)
      testsBad++;
    $display("Test %s done with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  // Serves one fetch, then gathers commits until the next fetch request
  task automatic issue(input wordT ins, output wordT addr, output int nCommit,
                       output regNumT cNum, output wordT cData);
    int   count;
    logic waiting;
    logic done;
    wordT heldAddr;
    count    = 0;
    waiting  = 1'b0;
    done     = 1'b0;
    nCommit  = 0;
    addr     = '0;
    cNum     = '0;
    cData    = '0;
    heldAddr = '0;
    fetchData <= ins;
    while (!done)
    begin
      @(posedge clk);
      if (fetchValid)
      begin
        if (waiting)
          compareVal("fetchAddr", fetchAddr, heldAddr);   // Held under back-pressure
        if (fetchReady)
        begin
          done = 1'b1;
          addr = fetchAddr;
        end
        else
        begin
          waiting  = 1'b1;
          heldAddr = fetchAddr;
        end
      end
      fetchReady <= !done && (({$random(seed)} % 100) < readyPct);
      count++;
      if (count > 300)
        stopOnTimeout("a fetch handshake");
    end
    count = 0;
    done  = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (regWriteValid)
      begin
        nCommit++;
        cNum  = regWriteNum;
        cData = regWriteData;
      end
      done = fetchValid;
      count++;
      if (count > 20)
        stopOnTimeout("the next fetch request");
    end
  endtask

  task automatic step(input wordT ins);
    wordT   addr;
    int     nCommit;
    regNumT cNum;
    wordT   cData;
    logic   wr;
    regNumT rd;
    wordT   val;
    wordT   npc;
    issue(ins, addr, nCommit, cNum, cData);
    compareVal("fetchAddr", addr, mPc);
    modelExec(ins, wr, rd, val, npc);
    compareVal("commitCount", 32'(nCommit), 32'(wr));
    if (wr && nCommit == 1)
    begin
      compareVal("regWriteNum", 32'(cNum), 32'(rd));
      compareVal("regWriteData", cData, val);
    end
    compareVal("fetchAddr", fetchAddr, npc);   // Next request goes to the model's target
  endtask

  function automatic wordT readbackAdd(input regNumT r);
    return {7'b0, 5'd0, 1'b0, r, 3'b0, 1'b0, r, 7'b0110011};   // add r, r, x0
  endfunction

  function automatic wordT randUpperJump();
    logic [4:0] rd;
    rd = randReg();
    case (2'(rnd()))
      2'd0:    return {20'(rnd()), rd, 7'b0110111};
      2'd1:    return {20'(rnd()), rd, 7'b0010111};
      2'd2:    return {20'(rnd()), rd, 7'b1101111};
      default: return {12'($random(seed) % 64), randReg(), 3'b0, rd, 7'b1100111};
    endcase
  endfunction

  function automatic wordT randBranch();
    logic [2:0] f3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    case ({$random(seed)} % 6)
      0:       f3 = 3'd0;
      1:       f3 = 3'd1;
      2:       f3 = 3'd4;
      3:       f3 = 3'd5;
      4:       f3 = 3'd6;
      default: f3 = 3'd7;
    endcase
    rs1 = randReg();
    rs2 = 1'(rnd()) ? rs1 : randReg();   // Equal operands half the time
    return {7'(rnd()), rs2, rs1, f3, 5'(rnd()), 7'b1100011};
  endfunction

  function automatic wordT randUnknown();
    case (2'(rnd()))
      2'd0:    return {25'(rnd()), 7'b0000011};   // Load
      2'd1:    return {25'(rnd()), 7'b0100011};   // Store
      2'd2:    return {25'(rnd()), 7'b1110011};
      default: return {17'(rnd()), 3'd2, 5'(rnd()), 7'b1100011};
    endcase
  endfunction

  initial
  begin
    int count;
    reset      = 1'b1;
    fetchReady = 1'b0;
    fetchData  = '0;
    mPc        = resetPc;
    for (int i = 0; i < 16; i++)
      mRegs[i] = '0;

    repeat (10)
    begin
      @(posedge clk);
      @(negedge clk);
      compareVal("fetchValid", 32'(fetchValid), 32'd0);
      compareVal("regWriteValid", 32'(regWriteValid), 32'd0);
    end
    @(posedge clk);
    reset <= 1'b0;
    count = 0;
    do
    begin
      @(posedge clk);
      count++;
      if (count > 20)
        stopOnTimeout("the first fetch");
    end
    while (!fetchValid);
    compareVal("fetchAddr", fetchAddr, resetPc);
    endTest("reset");

    repeat (200)
      step(randAlu());
    endTest("aluGroup");

    repeat (60)
      step(randUpperJump());
    endTest("upperAndJumps");

    repeat (60)
      step(randBranch());
    endTest("branches");

    readyPct = 20;   // Long stalls on the bus
    repeat (60)
      step(randAlu());
    for (int r = 1; r < 16; r++)
      step(readbackAdd(regNumT'(r)));
    readyPct = 70;
    endTest("backPressure");

    repeat (30)
      step(randUnknown());
    step(readbackAdd(4'd1));
    endTest("unknownOpcodes");

    $display("Tests run %0d, tests failed %0d, check errors %0d", testsRun, testsBad, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+test
logic/cpuPkg.sv
logic/decodeIf.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/executeUnit.sv
logic/registerBank.sv
logic/rv32Core.sv
test/coreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module coreTb -o coreSim
./obj_dir/coreSim > sim.log
cat sim.log

if grep -q "Simulation finished: PASS" sim.log
then
  exit 0
else
  exit 1
fi
